//--- rtl/vprof_pkg.sv
// Shared definitions for the vector profiling subsystem.
// Holds default sizes, opcode and register encodings, the packed
// instruction, event and read-response types and the opcode latency table.
// Every RTL file and the testbench reference model refer to it by scope.

package vprof_pkg;

  // Default sizes, overridden from the top level
  localparam int unsigned NrLanes    = 4;
  localparam int unsigned QueueDepth = 4;

  // Counter and vector length widths
  localparam int unsigned CntWidth = 64;
  localparam int unsigned VlWidth  = 8;

  // Vector opcodes
  typedef enum logic [1:0] {
    VADD   = 2'd0,
    VMUL   = 2'd1,
    VLOAD  = 2'd2,
    VSTORE = 2'd3
  } vop_e;

  // Dispatched instruction, 10 bits
  typedef struct packed {
    vop_e               op;
    logic [VlWidth-1:0] vl;
  } vinsn_t;

  // Scalar core stall events, one bit each
  typedef struct packed {
    logic dcache_miss;
    logic icache_miss;
    logic sb_full;
  } stall_evt_t;

  // Readable profiling registers
  typedef enum logic [2:0] {
    REG_RUNTIME = 3'd0,
    REG_DCACHE  = 3'd1,
    REG_ICACHE  = 3'd2,
    REG_SBFULL  = 3'd3,
    REG_STATUS  = 3'd4
  } perf_reg_e;

  // Pending read response, remembers which register it came from
  typedef struct packed {
    perf_reg_e           idx;
    logic [CntWidth-1:0] data;
  } perf_rsp_t;

  // Fixed cycles per opcode, before the length-dependent part
  function automatic int unsigned base_latency(vop_e op);
    unique case (op)
      VADD:    base_latency = 1;
      VMUL:    base_latency = 3;
      VLOAD:   base_latency = 4;
      VSTORE:  base_latency = 2;
      default: base_latency = 1;
    endcase
  endfunction

endpackage

//--- rtl/vec_exec_model.sv
// Stand-in for the vector unit: queues dispatched instructions and keeps
// each one busy for a fixed number of cycles.
// Exec cycles are the opcode latency plus vl over NrLanes, rounded up.
// Drives the dispatch ready and a combinational idle flag.

`timescale 1ns/1ps

module vec_exec_model #(
  parameter int unsigned NrLanes    = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                insn_valid_i,
  input  vprof_pkg::vinsn_t   insn_i,
  output logic                insn_ready_o,
  output logic                idle_o
);

  // Pointer, occupancy and timer widths
  localparam int unsigned PtrWidth   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW       = $clog2(QueueDepth + 1);
  localparam int unsigned TimerWidth = $clog2(2 ** vprof_pkg::VlWidth + 8);

  vprof_pkg::vinsn_t     queue_q [QueueDepth];
  logic [PtrWidth-1:0]   wptr_q, wptr_d;
  logic [PtrWidth-1:0]   rptr_q, rptr_d;
  logic [CntW-1:0]       count_q, count_d;
  logic [TimerWidth-1:0] timer_q, timer_d;
  logic                  push, pop;
  logic                  empty, full;
  vprof_pkg::vinsn_t     head;
  logic [TimerWidth-1:0] exec_cycles;

  assign empty = (count_q == '0);
  assign full  = (count_q == CntW'(QueueDepth));
  assign head  = queue_q[rptr_q];

  // Handshake toward the dispatcher
  assign insn_ready_o = !full;
  assign push         = insn_valid_i && insn_ready_o;

  // Next instruction starts once the timer has run out
  // The pop cycle is itself the first exec cycle
  assign pop = !empty && (timer_q == '0);

  // Opcode latency plus ceil(vl / NrLanes)
  assign exec_cycles = TimerWidth'(vprof_pkg::base_latency(head.op))
                     + TimerWidth'((head.vl + NrLanes - 1) / NrLanes);

  // No work queued and nothing left on the timer
  assign idle_o = empty && (timer_q == '0);

  always_comb begin
    wptr_d  = wptr_q;
    rptr_d  = rptr_q;
    count_d = count_q;
    timer_d = timer_q;
    // Circular write side
    if (push) begin
      wptr_d = (wptr_q == PtrWidth'(QueueDepth - 1)) ? '0 : wptr_q + 1'b1;
    end
    // Circular read side, timer reloaded with the remaining cycles
    if (pop) begin
      rptr_d  = (rptr_q == PtrWidth'(QueueDepth - 1)) ? '0 : rptr_q + 1'b1;
      timer_d = exec_cycles - 1'b1;
    end else if (timer_q != '0) begin
      timer_d = timer_q - 1'b1;
    end
    // Occupancy tracks both sides in the same cycle
    if (push && !pop) begin
      count_d = count_q + 1'b1;
    end else if (pop && !push) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
      timer_q <= '0;
    end else begin
      wptr_q  <= wptr_d;
      rptr_q  <= rptr_d;
      count_q <= count_d;
      timer_q <= timer_d;
    end
  end

  // Queue storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wptr_q] <= insn_i;
    end
  end

endmodule

//--- rtl/runtime_counter.sv
// Vector runtime counter.
// Starts on the first dispatched instruction when software enables it and
// keeps running while enabled or while the vector unit is busy.
// Copies the count into a buffer once the unit drains with no new
// instruction offered, and pulses snap_o toward the other counters.

`timescale 1ns/1ps

module runtime_counter (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           prof_en_i,
  input  logic                           insn_valid_i,
  input  logic                           idle_i,
  output logic                           active_o,
  output logic [vprof_pkg::CntWidth-1:0] runtime_o,
  output logic                           snap_o
);

  logic                           en_q, en_d;
  logic [vprof_pkg::CntWidth-1:0] cnt_q, cnt_d;
  logic [vprof_pkg::CntWidth-1:0] buf_q, buf_d;
  logic                           upd_q, upd_d;

  // Snapshot when a pending update meets an idle unit and no new request
  assign snap_o = upd_q && idle_i && !insn_valid_i;

  // Enable state
  always_comb begin
    if (!en_q) begin
      // Off: start on a dispatch while software allows it
      en_d = insn_valid_i && prof_en_i;
    end else begin
      // On: hold until software drops it and the unit is idle
      en_d = prof_en_i || !idle_i;
    end
  end

  // Free-running count, never cleared between bursts
  always_comb begin
    cnt_d = cnt_q;
    if (en_q) begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  // Update flag and buffer
  always_comb begin
    upd_d = upd_q;
    buf_d = buf_q;
    if (snap_o) begin
      upd_d = 1'b0;
      buf_d = cnt_q;
    end
    // A new dispatch always arms the next update
    if (insn_valid_i) begin
      upd_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q  <= 1'b0;
      cnt_q <= '0;
      upd_q <= 1'b0;
      buf_q <= '0;
    end else begin
      en_q  <= en_d;
      cnt_q <= cnt_d;
      upd_q <= upd_d;
      buf_q <= buf_d;
    end
  end

  assign active_o  = en_q;
  assign runtime_o = buf_q;

endmodule

//--- rtl/stall_counters.sv
// Scalar core stall counters.
// Counts data-cache miss, instruction-cache miss and scoreboard-full cycles
// while profiling is active, and snapshots them together with the runtime.

`timescale 1ns/1ps

module stall_counters (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           active_i,
  input  vprof_pkg::stall_evt_t          evt_i,
  input  logic                           snap_i,
  output logic [vprof_pkg::CntWidth-1:0] dcache_o,
  output logic [vprof_pkg::CntWidth-1:0] icache_o,
  output logic [vprof_pkg::CntWidth-1:0] sbfull_o
);

  localparam int unsigned NrEvents = 3;

  logic [NrEvents-1:0]            evt_vec;
  logic [vprof_pkg::CntWidth-1:0] cnt_q [NrEvents];
  logic [vprof_pkg::CntWidth-1:0] buf_q [NrEvents];

  // Index 0 dcache, 1 icache, 2 scoreboard full
  assign evt_vec = {evt_i.sb_full, evt_i.icache_miss, evt_i.dcache_miss};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NrEvents; i++) begin
        cnt_q[i] <= '0;
        buf_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NrEvents; i++) begin
        // Only events seen during the profiled window count
        if (active_i && evt_vec[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
        // Buffer takes the running value on the same edge as the runtime
        if (snap_i) begin
          buf_q[i] <= cnt_q[i];
        end
      end
    end
  end

  assign dcache_o = buf_q[0];
  assign icache_o = buf_q[1];
  assign sbfull_o = buf_q[2];

endmodule

//--- rtl/perf_regs.sv
// Register read port for the profiling buffers.
// Requests select a snapshot or the status word; the result sits in a
// one-entry response stage until the requester takes it.
// Status: bit 0 idle, bit 1 active, bit 2 fresh snapshot.

`timescale 1ns/1ps

module perf_regs (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           rd_req_valid_i,
  input  vprof_pkg::perf_reg_e           rd_req_i,
  output logic                           rd_req_ready_o,
  output logic                           rd_rsp_valid_o,
  output logic [vprof_pkg::CntWidth-1:0] rd_rsp_data_o,
  input  logic                           rd_rsp_ready_i,
  input  logic [vprof_pkg::CntWidth-1:0] runtime_i,
  input  logic [vprof_pkg::CntWidth-1:0] dcache_i,
  input  logic [vprof_pkg::CntWidth-1:0] icache_i,
  input  logic [vprof_pkg::CntWidth-1:0] sbfull_i,
  input  logic                           idle_i,
  input  logic                           active_i,
  input  logic                           snap_i
);

  logic                           rsp_valid_q;
  vprof_pkg::perf_rsp_t           rsp_q;
  logic                           fresh_q;
  logic                           req_fire;
  logic                           rsp_fire;
  logic [vprof_pkg::CntWidth-1:0] sel_data;

  // Stage can take a request when empty or draining this cycle
  assign rd_req_ready_o = !rsp_valid_q || rd_rsp_ready_i;
  assign req_fire       = rd_req_valid_i && rd_req_ready_o;
  assign rsp_fire       = rsp_valid_q && rd_rsp_ready_i;

  // Register select
  always_comb begin
    unique case (rd_req_i)
      vprof_pkg::REG_RUNTIME: sel_data = runtime_i;
      vprof_pkg::REG_DCACHE:  sel_data = dcache_i;
      vprof_pkg::REG_ICACHE:  sel_data = icache_i;
      vprof_pkg::REG_SBFULL:  sel_data = sbfull_i;
      vprof_pkg::REG_STATUS:  sel_data = {{(vprof_pkg::CntWidth - 3){1'b0}},
                                          fresh_q, active_i, idle_i};
      default:                sel_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      fresh_q     <= 1'b0;
    end else begin
      // Response valid the cycle after acceptance
      if (req_fire) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_fire) begin
        rsp_valid_q <= 1'b0;
      end
      // New snapshot wins over a runtime read in the same cycle
      if (snap_i) begin
        fresh_q <= 1'b1;
      end else if (rsp_fire && rsp_q.idx == vprof_pkg::REG_RUNTIME) begin
        fresh_q <= 1'b0;
      end
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_q.idx  <= rd_req_i;
      rsp_q.data <= sel_data;
    end
  end

  assign rd_rsp_valid_o = rsp_valid_q;
  assign rd_rsp_data_o  = rsp_q.data;

endmodule

//--- rtl/vprof_top.sv
// Top level of the vector profiling subsystem.
// Connects the vector unit model, the runtime and stall counters and the
// register read port. Lane count and queue depth are set here.

`timescale 1ns/1ps

module vprof_top #(
  parameter int unsigned NrLanes    = vprof_pkg::NrLanes,
  parameter int unsigned QueueDepth = vprof_pkg::QueueDepth
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           prof_en_i,
  // Instruction dispatch
  input  logic                           insn_valid_i,
  input  vprof_pkg::vinsn_t              insn_i,
  output logic                           insn_ready_o,
  // Scalar core stall events
  input  vprof_pkg::stall_evt_t          evt_i,
  // Register read port
  input  logic                           rd_req_valid_i,
  input  vprof_pkg::perf_reg_e           rd_req_i,
  output logic                           rd_req_ready_o,
  output logic                           rd_rsp_valid_o,
  output logic [vprof_pkg::CntWidth-1:0] rd_rsp_data_o,
  input  logic                           rd_rsp_ready_i
);

  logic                           idle;
  logic                           active;
  logic                           snap;
  logic [vprof_pkg::CntWidth-1:0] runtime;
  logic [vprof_pkg::CntWidth-1:0] dcache;
  logic [vprof_pkg::CntWidth-1:0] icache;
  logic [vprof_pkg::CntWidth-1:0] sbfull;

  vec_exec_model #(
    .NrLanes   (NrLanes   ),
    .QueueDepth(QueueDepth)
  ) i_vec_exec_model (
    .clk_i       (clk_i       ),
    .rst_ni      (rst_ni      ),
    .insn_valid_i(insn_valid_i),
    .insn_i      (insn_i      ),
    .insn_ready_o(insn_ready_o),
    .idle_o      (idle        )
  );

  // Sees the raw dispatch valid, not only accepted transfers
  runtime_counter i_runtime_counter (
    .clk_i       (clk_i       ),
    .rst_ni      (rst_ni      ),
    .prof_en_i   (prof_en_i   ),
    .insn_valid_i(insn_valid_i),
    .idle_i      (idle        ),
    .active_o    (active      ),
    .runtime_o   (runtime     ),
    .snap_o      (snap        )
  );

  stall_counters i_stall_counters (
    .clk_i   (clk_i  ),
    .rst_ni  (rst_ni ),
    .active_i(active ),
    .evt_i   (evt_i  ),
    .snap_i  (snap   ),
    .dcache_o(dcache ),
    .icache_o(icache ),
    .sbfull_o(sbfull )
  );

  perf_regs i_perf_regs (
    .clk_i         (clk_i         ),
    .rst_ni        (rst_ni        ),
    .rd_req_valid_i(rd_req_valid_i),
    .rd_req_i      (rd_req_i      ),
    .rd_req_ready_o(rd_req_ready_o),
    .rd_rsp_valid_o(rd_rsp_valid_o),
    .rd_rsp_data_o (rd_rsp_data_o ),
    .rd_rsp_ready_i(rd_rsp_ready_i),
    .runtime_i     (runtime       ),
    .dcache_i      (dcache        ),
    .icache_i      (icache        ),
    .sbfull_i      (sbfull        ),
    .idle_i        (idle          ),
    .active_i      (active        ),
    .snap_i        (snap          )
  );

endmodule

//--- verif/vprof_clk_gen.sv
// Clock and reset source for the profiling testbench.
// 20 ns clock; reset held low for ResetCycles rising edges, released on a falling edge.

`timescale 1ns/1ps

module vprof_clk_gen #(
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- verif/vprof_monitor.sv
// Checks module for the profiling testbench.
// Models the vector unit, runtime, stall and status snapshots from the observed
// dispatch, event and read traffic, and compares every read response in order.

`timescale 1ns/1ps

module vprof_monitor #(
  parameter int unsigned NrLanes = 4
) (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           prof_en_i,
  input logic                           insn_valid_i,
  input vprof_pkg::vinsn_t              insn_i,
  input logic                           insn_ready_i,
  input vprof_pkg::stall_evt_t          evt_i,
  input logic                           rd_req_valid_i,
  input vprof_pkg::perf_reg_e           rd_req_i,
  input logic                           rd_req_ready_i,
  input logic                           rd_rsp_valid_i,
  input logic [vprof_pkg::CntWidth-1:0] rd_rsp_data_i,
  input logic                           rd_rsp_ready_i
);

  int unsigned          err_count;
  int unsigned          check_count;
  string                cur_test;
  logic [63:0]          exp_q [$];
  vprof_pkg::perf_reg_e idx_q [$];
  logic [63:0]          run_sum, gap_cnt, last_rt;
  logic [63:0]          evt_run [3];
  logic [63:0]          evt_snap [3];
  logic                 in_gap, fresh;
  // Reference state of the vector unit and the runtime counter
  int unsigned          work;
  logic                 idle_m, snap_m, en_m, upd_m;

  // Reference timing for one instruction
  function automatic int unsigned exec_cycles(vprof_pkg::vinsn_t insn);
    return vprof_pkg::base_latency(insn.op) + (int'(insn.vl) + NrLanes - 1) / NrLanes;
  endfunction

  // Expected register contents at the moment a request is accepted
  function automatic logic [63:0] expected_value(vprof_pkg::perf_reg_e idx);
    case (idx)
      vprof_pkg::REG_RUNTIME: return last_rt;
      vprof_pkg::REG_DCACHE:  return evt_snap[0];
      vprof_pkg::REG_ICACHE:  return evt_snap[1];
      vprof_pkg::REG_SBFULL:  return evt_snap[2];
      default:                return {61'd0, fresh, en_m, idle_m};
    endcase
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    logic [63:0]          exp_v;
    vprof_pkg::perf_reg_e idx_v;
    logic                 rt_taken;
    if (!rst_ni) begin
      exp_q.delete();
      idx_q.delete();
      {run_sum, gap_cnt, last_rt} = '0;
      evt_run  = '{default: '0};
      evt_snap = '{default: '0};
      in_gap = 1'b1;
      fresh  = 1'b0;
      work   = 0;
      idle_m = 1'b1;
      snap_m = 1'b0;
      en_m   = 1'b0;
      upd_m  = 1'b0;
    end else begin
      rt_taken = 1'b0;
      // Unit is idle once all accepted work has been executed
      idle_m = (work == 0);
      snap_m = upd_m && idle_m && !insn_valid_i;
      // Responses retire in request order
      if (rd_rsp_valid_i && rd_rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Error %s: response returned with no request pending", cur_test);
          err_count++;
        end else begin
          exp_v  = exp_q.pop_front();
          idx_v  = idx_q.pop_front();
          rt_taken = (idx_v == vprof_pkg::REG_RUNTIME);
          check_count++;
          if (rd_rsp_data_i !== exp_v) begin
            $display("Error %s: %s expected %0h actual %0h", cur_test, idx_v.name(),
                     exp_v, rd_rsp_data_i);
            err_count++;
          end
        end
      end
      if (rd_req_valid_i && rd_req_ready_i) begin
        if (rd_rsp_valid_i && !rd_rsp_ready_i) begin
          $display("Error %s: request accepted while a response was waiting", cur_test);
          err_count++;
        end
        exp_q.push_back(expected_value(rd_req_i));
        idx_q.push_back(rd_req_i);
      end
      if (snap_m) begin
        fresh = 1'b1;
      end else if (rt_taken) begin
        fresh = 1'b0;
      end
      // Snapshot closes the burst, the next gap starts on this edge
      if (snap_m) begin
        last_rt  = last_rt + gap_cnt + run_sum;
        run_sum  = '0;
        gap_cnt  = '0;
        in_gap   = 1'b1;
        evt_snap = evt_run;
      end
      if (en_m) begin
        evt_run[0] += evt_i.dcache_miss;
        evt_run[1] += evt_i.icache_miss;
        evt_run[2] += evt_i.sb_full;
        if (in_gap) begin
          gap_cnt++;
        end
      end
      // First transfer ends the gap; exec time counts only when enabled
      if (insn_valid_i && insn_ready_i) begin
        in_gap = 1'b0;
        if (prof_en_i) begin
          run_sum += exec_cycles(insn_i);
        end
      end
      // Any offered instruction arms the next snapshot
      if (snap_m) begin
        upd_m = 1'b0;
      end
      if (insn_valid_i) begin
        upd_m = 1'b1;
      end
      // Enable starts on a dispatch with software enable, then holds while busy
      if (!en_m) begin
        en_m = insn_valid_i && prof_en_i;
      end else begin
        en_m = prof_en_i || !idle_m;
      end
      // Work is executed back to back, one cycle per edge
      if (work != 0) begin
        work--;
      end
      if (insn_valid_i && insn_ready_i) begin
        work += exec_cycles(insn_i);
      end
    end
  end

endmodule

//--- verif/vprof_chk.sv
// Concurrent assertions for the profiling top level, attached with bind.
// Covers handshake stability, response timing, snapshot pulses and reset values.

`timescale 1ns/1ps

module vprof_chk (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           insn_valid_i,
  input vprof_pkg::vinsn_t              insn_i,
  input logic                           insn_ready_o,
  input logic                           rd_req_valid_i,
  input vprof_pkg::perf_reg_e           rd_req_i,
  input logic                           rd_req_ready_o,
  input logic                           rd_rsp_valid_o,
  input logic [vprof_pkg::CntWidth-1:0] rd_rsp_data_o,
  input logic                           rd_rsp_ready_i,
  input logic                           idle_i,
  input logic                           snap_i
);

  int unsigned fail_cnt = 0;

  insn_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_valid_i && !insn_ready_o |=> insn_valid_i && $stable(insn_i))
    else begin $error("Dispatch dropped or changed before ready"); fail_cnt++; end
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req_valid_i && !rd_req_ready_o |=> rd_req_valid_i && $stable(rd_req_i))
    else begin $error("Read request dropped or changed before ready"); fail_cnt++; end
  rsp_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req_valid_i && rd_req_ready_o |=> rd_rsp_valid_o)
    else begin $error("No response the cycle after an accepted request"); fail_cnt++; end
  rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_rsp_valid_o && !rd_rsp_ready_i |=> rd_rsp_valid_o && $stable(rd_rsp_data_o))
    else begin $error("Waiting response dropped or changed"); fail_cnt++; end
  // Snapshot only in the first idle cycle after busy work, so it lasts one cycle
  snap_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    snap_i |-> $rose(idle_i))
    else begin $error("Snapshot pulse not single or not idle"); fail_cnt++; end
  reset_vals: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> insn_ready_o && rd_req_ready_o && !rd_rsp_valid_o)
    else begin $error("Wrong handshake state after reset"); fail_cnt++; end

endmodule

bind vprof_top vprof_chk chk (.*, .idle_i(idle), .snap_i(snap));

//--- verif/vprof_tb.sv
// Testbench top for the vector profiling subsystem.
// Runs bursts, stall events, disabled profiling, read back-pressure and reruns;
// the monitor compares reads, this module reports per test and at the end.

`timescale 1ns/1ps

module vprof_tb;

  localparam int unsigned NrLanes    = 4;
  localparam int unsigned BurstLen   = 8;
  localparam int unsigned NrBursts   = 6;
  localparam int unsigned NrTests    = 5;
  localparam int unsigned WorstExec  = 4 + (255 + NrLanes - 1) / NrLanes;
  localparam int unsigned CycleLimit = NrBursts * BurstLen * WorstExec + NrTests * 200;

  logic                  clk_i, rst_ni, prof_en_i, insn_valid_i, insn_ready_o;
  logic                  rd_req_valid_i, rd_req_ready_o, rd_rsp_valid_o, rd_rsp_ready_i;
  logic                  evt_on;
  vprof_pkg::vinsn_t     insn_i;
  vprof_pkg::stall_evt_t evt_i;
  vprof_pkg::perf_reg_e  rd_req_i;
  logic [63:0]           rd_rsp_data_o, rdata, rt_prev;
  int unsigned           cycles, tb_errs, tests_run, tests_failed, errs_at_start, seed;
  string                 test_name;

  vprof_clk_gen #(.ResetCycles(16)) i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  vprof_top #(.NrLanes(NrLanes), .QueueDepth(4)) dut (.*);

  vprof_monitor #(.NrLanes(NrLanes)) mon (
    .clk_i, .rst_ni, .prof_en_i, .insn_valid_i, .insn_i, .insn_ready_i(insn_ready_o),
    .evt_i, .rd_req_valid_i, .rd_req_i,
    .rd_req_ready_i(rd_req_ready_o), .rd_rsp_valid_i(rd_rsp_valid_o),
    .rd_rsp_data_i(rd_rsp_data_o), .rd_rsp_ready_i
  );

  // Run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > CycleLimit) begin
      $display("Run stopped after the cycle limit of %0d", CycleLimit);
      $display("Simulation failed");
      $finish;
    end
  end

  // Random stall events while enabled
  always @(negedge clk_i) begin
    evt_i = evt_on ? vprof_pkg::stall_evt_t'($urandom_range(0, 7)) : '0;
  end

  function automatic int unsigned total_errors();
    return mon.err_count + dut.chk.fail_cnt + tb_errs;
  endfunction

  task automatic start_test(input string name);
    test_name     = name;
    mon.cur_test  = name;
    errs_at_start = total_errors();
  endtask

  task automatic end_test();
    tests_run++;
    if (total_errors() > errs_at_start) begin
      tests_failed++;
    end
    $display("Test %s %s", test_name, (total_errors() > errs_at_start) ? "FAIL" : "PASS");
  endtask

  // Back to back dispatch, valid held until each transfer
  task automatic run_burst(input int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      insn_valid_i = 1'b1;
      insn_i.op    = vprof_pkg::vop_e'($urandom_range(0, 3));
      insn_i.vl    = 8'($urandom_range(0, 63));
      while (!insn_ready_o) @(negedge clk_i);
      @(negedge clk_i);
    end
    insn_valid_i = 1'b0;
  endtask

  task automatic read_reg(input vprof_pkg::perf_reg_e idx, output logic [63:0] data);
    rd_req_valid_i = 1'b1;
    rd_req_i       = idx;
    while (!rd_req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    rd_req_valid_i = 1'b0;
    while (!(rd_rsp_valid_o && rd_rsp_ready_i)) @(negedge clk_i);
    data = rd_rsp_data_o;
    @(negedge clk_i);
  endtask

  // Poll status until a new snapshot is flagged
  task automatic wait_fresh();
    logic [63:0] st;
    st = '0;
    while (!st[2]) read_reg(vprof_pkg::REG_STATUS, st);
  endtask

  task automatic expect_value(input string what, input logic [63:0] exp, act);
    if (exp !== act) begin
      $display("Error %s: %s expected %0h actual %0h", test_name, what, exp, act);
      tb_errs++;
    end
  endtask

  // Random response stalls; request held until accepted, then drained
  task automatic stress_reads(input int unsigned nreq);
    int unsigned sent, span;
    logic        acc;
    sent = 0;
    span = 0;
    acc  = 1'b1;
    while (sent < nreq || mon.exp_q.size() != 0) begin
      if (span == 0) begin
        rd_rsp_ready_i = 1'($urandom_range(0, 1));
        span           = $urandom_range(1, 6);
      end
      span--;
      if (sent >= nreq) rd_rsp_ready_i = 1'b1;
      if (acc) rd_req_i = vprof_pkg::perf_reg_e'($urandom_range(0, 4));
      rd_req_valid_i = (sent < nreq);
      #1;
      acc = rd_req_valid_i && rd_req_ready_o;
      if (acc) sent++;
      @(negedge clk_i);
    end
    rd_req_valid_i = 1'b0;
    rd_rsp_ready_i = 1'b1;
  endtask

  initial begin
    seed = $urandom(32'h9e8e_ad81);
    {prof_en_i, insn_valid_i, rd_req_valid_i, evt_on} = '0;
    rd_rsp_ready_i = 1'b1;
    insn_i         = '0;
    evt_i          = '0;
    rd_req_i       = vprof_pkg::REG_RUNTIME;
    {cycles, tb_errs, tests_run, tests_failed} = '0;
    @(posedge rst_ni);
    @(negedge clk_i);

    start_test("single_burst");
    prof_en_i = 1'b1;
    run_burst(BurstLen);
    wait_fresh();
    read_reg(vprof_pkg::REG_RUNTIME, rdata);
    end_test();

    start_test("stall_events");
    evt_on = 1'b1;
    run_burst(BurstLen);
    evt_on = 1'b0;
    wait_fresh();
    read_reg(vprof_pkg::REG_DCACHE, rdata);
    read_reg(vprof_pkg::REG_ICACHE, rdata);
    read_reg(vprof_pkg::REG_SBFULL, rdata);
    end_test();

    start_test("profiling_disabled");
    prof_en_i = 1'b0;
    repeat (4) @(negedge clk_i);
    // Clears the fresh flag left by the previous burst
    read_reg(vprof_pkg::REG_RUNTIME, rdata);
    run_burst(BurstLen);
    wait_fresh();
    read_reg(vprof_pkg::REG_RUNTIME, rdata);
    // Reference runtime before the second disabled burst
    rt_prev = mon.last_rt;
    read_reg(vprof_pkg::REG_STATUS, rdata);
    expect_value("status active bit", 64'd0, {63'd0, rdata[1]});
    run_burst(BurstLen);
    wait_fresh();
    read_reg(vprof_pkg::REG_RUNTIME, rdata);
    expect_value("runtime after disabled burst", rt_prev, rdata);
    end_test();

    start_test("read_backpressure");
    stress_reads(12);
    end_test();

    start_test("fresh_and_rerun");
    prof_en_i = 1'b1;
    read_reg(vprof_pkg::REG_RUNTIME, rdata);
    read_reg(vprof_pkg::REG_STATUS, rdata);
    expect_value("status fresh bit", 64'd0, {63'd0, rdata[2]});
    run_burst(BurstLen);
    wait_fresh();
    read_reg(vprof_pkg::REG_RUNTIME, rdata);
    repeat ($urandom_range(5, 20)) @(negedge clk_i);
    run_burst(BurstLen);
    wait_fresh();
    read_reg(vprof_pkg::REG_RUNTIME, rdata);
    end_test();

    $display("Tests %0d run, %0d failed, %0d reads checked, %0d errors",
             tests_run, tests_failed, mon.check_count, total_errors());
    if (total_errors() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sources.f
rtl/vprof_pkg.sv
rtl/vec_exec_model.sv
rtl/runtime_counter.sv
rtl/stall_counters.sv
rtl/perf_regs.sv
rtl/vprof_top.sv
verif/vprof_clk_gen.sv
verif/vprof_monitor.sv
verif/vprof_chk.sv
verif/vprof_tb.sv
